//--- design/io_defines.svh
// Console peripheral I/O block shared parameters
// Sizes and rates for the gamepad poller, audio tick and event FIFOs

`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Number of buttons shifted out by the serial gamepad
`define IO_PAD_BITS 12

// Clock cycles between gamepad polls
// A poll takes 26 cycles from start to word, so this must stay above that
`define IO_POLL_DIV 64

// Clock cycles between audio sample ticks
`define IO_SAMPLE_DIV 32

// Entries in each event FIFO
`define IO_FIFO_DEPTH 4

`endif

//--- design/pad_types_pkg.sv
// Gamepad types for the console I/O block
// Button word layout and the position of each button in it

`include "io_defines.svh"

package pad_types_pkg;

    // One bit per button, 1 means pressed
    // Bit 0 holds the first bit shifted out of the pad
    typedef logic [`IO_PAD_BITS-1:0] pad_word_t;

    // Bit positions in the order the pad shifts them out
    typedef enum logic [3:0] {
        b_2    = 4'd0,
        y      = 4'd1,
        select = 4'd2,
        start  = 4'd3,
        up     = 4'd4,
        down   = 4'd5,
        b_3    = 4'd6,
        b_1    = 4'd7,
        a      = 4'd8,
        x      = 4'd9,
        l      = 4'd10,
        r      = 4'd11
    } pad_button_e;

endpackage

//--- design/audio_types_pkg.sv
// Audio types for the console I/O block
// Signed DAC samples and the stereo frame that carries a pair of them

`include "io_defines.svh"

package audio_types_pkg;

    // Width of one DAC sample
    localparam int AUDIO_SAMPLE_BITS = 16;

    // Two's complement sample as the DAC expects it
    typedef logic signed [AUDIO_SAMPLE_BITS-1:0] audio_sample_t;

    // Left channel sits in the upper half of the packed frame
    typedef struct packed {
        audio_sample_t l;
        audio_sample_t r;
    } audio_frame_t;

endpackage

//--- design/io_control.sv
// I/O control for the console peripheral block
// Generates poll and sample ticks, filters unchanged button words,
// pops audio frames on each sample tick and counts underruns

`timescale 1ns/1ps

`include "io_defines.svh"

module io_control import pad_types_pkg::*; (
    input  logic       clk_2x,
    input  logic       rst_n,
    input  logic       pad_busy,
    input  logic       word_valid,
    input  pad_word_t  pad_word,
    output logic       poll_start,
    output logic       pad_push,
    output pad_word_t  pad_push_data,
    input  logic       audio_empty,
    output logic       audio_pop,
    output logic [7:0] audio_underruns
);

    localparam int POLL_W   = $clog2(`IO_POLL_DIV);
    localparam int SAMPLE_W = $clog2(`IO_SAMPLE_DIV);

    logic [POLL_W-1:0]   poll_cnt;
    logic [SAMPLE_W-1:0] sample_cnt;
    logic                poll_tick;
    logic                sample_tick;
    pad_word_t           last_word;

    // Each tick fires on the last count of its period
    // so the first one lands a full period after reset
    assign poll_tick   = (poll_cnt == POLL_W'(`IO_POLL_DIV - 1));
    assign sample_tick = (sample_cnt == SAMPLE_W'(`IO_SAMPLE_DIV - 1));

    // A tick that lands while the poller is still busy is skipped
    assign poll_start = poll_tick && !pad_busy;

    // Pop only when a frame is waiting, otherwise the tick is an underrun
    assign audio_pop = sample_tick && !audio_empty;

    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            poll_cnt   <= '0;
            sample_cnt <= '0;
        end else begin
            poll_cnt   <= poll_tick ? '0 : poll_cnt + 1'b1;
            sample_cnt <= sample_tick ? '0 : sample_cnt + 1'b1;
        end
    end

    // Change detection runs one cycle behind word_valid
    // The new word is recorded whether or not it gets queued
    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            pad_push  <= 1'b0;
            last_word <= '0;
        end else begin
            pad_push <= 1'b0;
            if (word_valid) begin
                pad_push  <= (pad_word != last_word);
                last_word <= pad_word;
            end
        end
    end

    // Word handed to the pad FIFO along with pad_push
    always_ff @(posedge clk_2x) begin
        if (word_valid) begin
            pad_push_data <= pad_word;
        end
    end

    // Underrun count sticks at its maximum rather than wrapping
    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            audio_underruns <= 8'd0;
        end else if (sample_tick && audio_empty && (audio_underruns != 8'hff)) begin
            audio_underruns <= audio_underruns + 8'd1;
        end
    end

endmodule

//--- design/pad_poller.sv
// Serial gamepad poller
// Latches the pad, clocks out the button bits and assembles the button word

`timescale 1ns/1ps

`include "io_defines.svh"

module pad_poller import pad_types_pkg::*; (
    input  logic      clk_2x,
    input  logic      rst_n,
    input  logic      poll_start,
    output logic      pad_latch,
    output logic      pad_clk,
    input  logic      pad_data,
    output logic      pad_busy,
    output logic      word_valid,
    output pad_word_t pad_word
);

    localparam int SLOT_W = $clog2(`IO_PAD_BITS);

    logic [SLOT_W-1:0] slot;
    logic              phase;
    pad_word_t         shift_q;

    // Sequence per poll
    // One latch cycle, then one two cycle slot per button with pad_clk
    // low then high, then word_valid, 26 cycles after poll_start in all
    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            pad_latch  <= 1'b0;
            pad_clk    <= 1'b0;
            pad_busy   <= 1'b0;
            word_valid <= 1'b0;
            slot       <= '0;
            phase      <= 1'b0;
        end else begin
            pad_latch  <= 1'b0;
            word_valid <= 1'b0;
            if (poll_start && !pad_busy) begin
                pad_latch <= 1'b1;
                pad_busy  <= 1'b1;
                slot      <= '0;
                phase     <= 1'b0;
            end else if (pad_busy) begin
                if (word_valid) begin
                    // Word has been presented, poll is over
                    pad_busy <= 1'b0;
                end else if (pad_latch) begin
                    // Latch drops here, first slot begins with pad_clk low
                    pad_clk <= 1'b0;
                end else if (!phase) begin
                    pad_clk <= 1'b1;
                    phase   <= 1'b1;
                end else begin
                    pad_clk <= 1'b0;
                    phase   <= 1'b0;
                    if (slot == SLOT_W'(`IO_PAD_BITS - 1)) begin
                        word_valid <= 1'b1;
                    end else begin
                        slot <= slot + 1'b1;
                    end
                end
            end
        end
    end

    // The pad drives data low for a pressed button
    // Capture happens on the edge that raises pad_clk, before the pad moves on
    // Shifting in from the top leaves the first bit at position 0
    always_ff @(posedge clk_2x) begin
        if (pad_busy && !word_valid && !pad_latch && !phase) begin
            shift_q <= {~pad_data, shift_q[`IO_PAD_BITS-1:1]};
        end
    end

    assign pad_word = shift_q;

endmodule

//--- design/event_fifo.sv
// First-word-fall-through FIFO with a selectable payload type
// Used for both button events and stereo audio frames

`timescale 1ns/1ps

`include "io_defines.svh"

module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `IO_FIFO_DEPTH
) (
    input  logic     clk_2x,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // A push into a full FIFO is dropped, even when a pop happens in the same cycle
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Oldest entry is always visible without a pop
    assign head = mem[rd_ptr];

    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk_2x) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- design/audio_output.sv
// Audio DAC output stage
// Takes the popped stereo frame and presents it to the DAC with a valid strobe

`timescale 1ns/1ps

`include "io_defines.svh"

module audio_output import audio_types_pkg::*; (
    input  logic          clk_2x,
    input  logic          rst_n,
    input  logic          audio_pop,
    input  audio_frame_t  frame,
    output logic          audio_output_valid,
    output audio_sample_t audio_output_l,
    output audio_sample_t audio_output_r
);

    // Strobe marks the cycle right after the pop
    always_ff @(posedge clk_2x or negedge rst_n) begin
        if (!rst_n) begin
            audio_output_valid <= 1'b0;
        end else begin
            audio_output_valid <= audio_pop;
        end
    end

    // Samples are taken from the FIFO head in the pop cycle
    // and held on the DAC lines until the next pop
    always_ff @(posedge clk_2x) begin
        if (audio_pop) begin
            audio_output_l <= frame.l;
            audio_output_r <= frame.r;
        end
    end

endmodule

//--- design/console_io_top.sv
// Console peripheral I/O top level
// Gamepad poller with a change event queue and a buffered stereo audio output

`timescale 1ns/1ps

`include "io_defines.svh"

module console_io_top import pad_types_pkg::*, audio_types_pkg::*; (
    input  logic          clk_2x,
    input  logic          rst_n,
    output logic          pad_latch,
    output logic          pad_clk,
    input  logic          pad_data,
    input  logic          pad_rd,
    output pad_word_t     pad_rd_data,
    output logic          pad_empty,
    input  logic          audio_wr,
    input  audio_sample_t audio_wr_l,
    input  audio_sample_t audio_wr_r,
    output logic          audio_full,
    output logic          audio_output_valid,
    output audio_sample_t audio_output_l,
    output audio_sample_t audio_output_r,
    output logic [7:0]    audio_underruns
);

    logic         poll_start;
    logic         pad_busy;
    logic         word_valid;
    pad_word_t    pad_word;
    logic         pad_push;
    pad_word_t    pad_push_data;
    logic         audio_pop;
    logic         audio_empty;
    audio_frame_t audio_wr_frame;
    audio_frame_t audio_head;

    // Host writes left and right together as one frame
    assign audio_wr_frame = '{l: audio_wr_l, r: audio_wr_r};

    io_control u_io_control (
        .clk_2x          (clk_2x),
        .rst_n           (rst_n),
        .pad_busy        (pad_busy),
        .word_valid      (word_valid),
        .pad_word        (pad_word),
        .poll_start      (poll_start),
        .pad_push        (pad_push),
        .pad_push_data   (pad_push_data),
        .audio_empty     (audio_empty),
        .audio_pop       (audio_pop),
        .audio_underruns (audio_underruns)
    );

    pad_poller u_pad_poller (
        .clk_2x     (clk_2x),
        .rst_n      (rst_n),
        .poll_start (poll_start),
        .pad_latch  (pad_latch),
        .pad_clk    (pad_clk),
        .pad_data   (pad_data),
        .pad_busy   (pad_busy),
        .word_valid (word_valid),
        .pad_word   (pad_word)
    );

    // Button events, popped directly by the host
    // A full queue simply drops new events, so its full flag goes nowhere
    event_fifo #(.payload_t(pad_word_t), .DEPTH(`IO_FIFO_DEPTH)) u_pad_fifo (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .push      (pad_push),
        .push_data (pad_push_data),
        .pop       (pad_rd),
        .head      (pad_rd_data),
        .empty     (pad_empty),
        .full      ()
    );

    // Audio frames, drained one per sample tick
    event_fifo #(.payload_t(audio_frame_t), .DEPTH(`IO_FIFO_DEPTH)) u_audio_fifo (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .push      (audio_wr),
        .push_data (audio_wr_frame),
        .pop       (audio_pop),
        .head      (audio_head),
        .empty     (audio_empty),
        .full      (audio_full)
    );

    audio_output u_audio_output (
        .clk_2x             (clk_2x),
        .rst_n              (rst_n),
        .audio_pop          (audio_pop),
        .frame              (audio_head),
        .audio_output_valid (audio_output_valid),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r)
    );

endmodule

//--- tb/console_io_chk.sv
// Protocol checker for the console peripheral I/O block
// Bound into the top level to check poll timing, FIFO pops and the DAC strobe

`timescale 1ns/1ps

`include "io_defines.svh"

module console_io_chk (
    input logic clk_2x,
    input logic rst_n,
    input logic poll_start,
    input logic word_valid,
    input logic pad_latch,
    input logic pad_rd,
    input logic pad_empty,
    input logic audio_pop,
    input logic audio_empty,
    input logic audio_output_valid
);

    // Latch cycle, twelve two cycle slots and the word cycle
    localparam int POLL_LATENCY = 26;
    // Quiet cycles required between two DAC strobes
    localparam int VALID_GAP    = `IO_SAMPLE_DIV - 1;

    int fail_count = 0;

    poll_to_word: assert property (@(posedge clk_2x) disable iff (!rst_n)
        poll_start |-> ##POLL_LATENCY word_valid)
        else begin
            $error("word_valid missing %0d cycles after poll_start", POLL_LATENCY);
            fail_count++;
        end

    latch_width: assert property (@(posedge clk_2x) disable iff (!rst_n)
        pad_latch |=> !pad_latch)
        else begin
            $error("pad_latch stayed high for more than one cycle");
            fail_count++;
        end

    pop_to_valid: assert property (@(posedge clk_2x) disable iff (!rst_n)
        audio_pop |=> audio_output_valid)
        else begin
            $error("audio_output_valid did not follow audio_pop");
            fail_count++;
        end

    pad_pop_empty: assert property (@(posedge clk_2x) disable iff (!rst_n)
        !(pad_rd && pad_empty))
        else begin
            $error("pad FIFO popped while empty");
            fail_count++;
        end

    audio_pop_empty: assert property (@(posedge clk_2x) disable iff (!rst_n)
        !(audio_pop && audio_empty))
        else begin
            $error("audio FIFO popped while empty");
            fail_count++;
        end

    valid_spacing: assert property (@(posedge clk_2x) disable iff (!rst_n)
        audio_output_valid |=> (!audio_output_valid)[*VALID_GAP])
        else begin
            $error("audio_output_valid pulses closer than %0d cycles", `IO_SAMPLE_DIV);
            fail_count++;
        end

endmodule

bind console_io_top console_io_chk u_chk (
    .clk_2x             (clk_2x),
    .rst_n              (rst_n),
    .poll_start         (poll_start),
    .word_valid         (word_valid),
    .pad_latch          (pad_latch),
    .pad_rd             (pad_rd),
    .pad_empty          (pad_empty),
    .audio_pop          (audio_pop),
    .audio_empty        (audio_empty),
    .audio_output_valid (audio_output_valid)
);

//--- tb/console_io_tb.sv
// Testbench for the console peripheral I/O block
// Models a serial gamepad, writes host audio frames and checks events and DAC samples

`timescale 1ns/1ps

`include "io_defines.svh"

module console_io_tb import pad_types_pkg::*, audio_types_pkg::*; ();

    localparam int MAX_CYCLES = 4000;

    logic          clk_2x;
    logic          rst_n;
    logic          pad_latch;
    logic          pad_clk;
    logic          pad_data;
    logic          pad_rd;
    pad_word_t     pad_rd_data;
    logic          pad_empty;
    logic          audio_wr;
    audio_sample_t audio_wr_l;
    audio_sample_t audio_wr_r;
    logic          audio_full;
    logic          audio_output_valid;
    audio_sample_t audio_output_l;
    audio_sample_t audio_output_r;
    logic [7:0]    audio_underruns;

    // Gamepad model state, all ones means no button pressed on the wire
    pad_word_t     buttons;
    pad_word_t     pad_shift = '1;
    logic          pad_clk_prev = 1'b0;

    int            errors = 0;
    int            cycle_count = 0;
    logic [31:0]   lcg_state;
    audio_frame_t  expected_frames[$];

    console_io_top u_dut (
        .clk_2x             (clk_2x),
        .rst_n              (rst_n),
        .pad_latch          (pad_latch),
        .pad_clk            (pad_clk),
        .pad_data           (pad_data),
        .pad_rd             (pad_rd),
        .pad_rd_data        (pad_rd_data),
        .pad_empty          (pad_empty),
        .audio_wr           (audio_wr),
        .audio_wr_l         (audio_wr_l),
        .audio_wr_r         (audio_wr_r),
        .audio_full         (audio_full),
        .audio_output_valid (audio_output_valid),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r),
        .audio_underruns    (audio_underruns)
    );

    initial begin
        clk_2x = 1'b0;
        forever #50 clk_2x = ~clk_2x;
    end

    // Pad snapshots the buttons on latch and moves one bit on each rising pad_clk
    // Data is active low and changes only on the falling clock edge
    always @(negedge clk_2x) begin
        if (pad_latch) begin
            pad_shift <= ~buttons;
        end else if (pad_clk && !pad_clk_prev) begin
            pad_shift <= {1'b1, pad_shift[`IO_PAD_BITS-1:1]};
        end
        pad_clk_prev <= pad_clk;
    end

    assign pad_data = pad_shift[0];

    // Hard stop in case the DUT never answers
    always @(posedge clk_2x) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better ones, zero is avoided
    function pad_word_t random_pattern();
        logic [31:0] rnd;
        rnd = next_random();
        return (rnd[31:20] == '0) ? pad_word_t'(1) : rnd[31:20];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] t=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_2x);
    endtask

    task automatic pop_button_event();
        assert (!pad_empty) else report_failure("no button event was queued to read");
        if (!pad_empty) begin
            pad_rd = 1'b1;
            @(negedge clk_2x);
            pad_rd = 1'b0;
        end
    endtask

    // With the audio FIFO empty every sample tick bumps the underrun count
    // so its change marks the tick, leaving a full period before the next one
    task automatic sync_to_sample_tick();
        logic [7:0] start;
        int         waited;
        start  = audio_underruns;
        waited = 0;
        while (audio_underruns == start && waited < 2 * `IO_SAMPLE_DIV) begin
            @(negedge clk_2x);
            waited++;
        end
        assert (audio_underruns != start) else report_failure("no sample tick was seen");
    endtask

    // Frames past the depth of the FIFO are dropped and not expected back
    task automatic write_frames(input int count, input int kept);
        logic [31:0]  rnd;
        audio_frame_t frame;
        for (int i = 0; i < count; i++) begin
            rnd     = next_random();
            frame.l = rnd[31:16];
            rnd     = next_random();
            frame.r = rnd[31:16];
            audio_wr   = 1'b1;
            audio_wr_l = frame.l;
            audio_wr_r = frame.r;
            if (i < kept) begin
                expected_frames.push_back(frame);
            end
            @(negedge clk_2x);
        end
        audio_wr = 1'b0;
    endtask

    task automatic expect_frames();
        audio_frame_t exp;
        int           waited;
        while (expected_frames.size() > 0) begin
            exp    = expected_frames.pop_front();
            waited = 0;
            @(negedge clk_2x);
            while (!audio_output_valid && waited < 2 * `IO_SAMPLE_DIV) begin
                @(negedge clk_2x);
                waited++;
            end
            assert (audio_output_valid) else report_failure("an audio frame never reached the DAC");
            check_value("audio_output_l", exp.l, audio_output_l);
            check_value("audio_output_r", exp.r, audio_output_r);
        end
    endtask

    task automatic expect_no_frames(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_2x);
            assert (!audio_output_valid) else report_failure("a dropped audio frame reached the DAC");
        end
    endtask

    initial begin
        pad_word_t  first;
        pad_word_t  second;
        logic [7:0] base;
        rst_n      = 1'b0;
        pad_rd     = 1'b0;
        audio_wr   = 1'b0;
        audio_wr_l = '0;
        audio_wr_r = '0;
        buttons    = '0;
        lcg_state  = 32'h65ba_d7d0;
        wait_cycles(16);
        rst_n = 1'b1;

        // Idle state straight out of reset
        check_value("pad_latch", 0, pad_latch);
        check_value("pad_clk", 0, pad_clk);
        check_value("audio_output_valid", 0, audio_output_valid);
        check_value("pad_empty", 1, pad_empty);
        check_value("audio_full", 0, audio_full);
        check_value("audio_underruns", 0, audio_underruns);

        // New pattern held for two polls gives exactly one event
        first   = random_pattern();
        buttons = first;
        wait_cycles(2 * `IO_POLL_DIV);
        check_value("pad_empty", 0, pad_empty);
        check_value("pad_rd_data", first, pad_rd_data);
        pop_button_event();
        check_value("pad_empty", 1, pad_empty);

        // Same pattern again is filtered, a different one is queued once
        wait_cycles(3 * `IO_POLL_DIV);
        check_value("pad_empty", 1, pad_empty);
        second = random_pattern();
        if (second == first) begin
            second = ~first;
        end
        buttons = second;
        wait_cycles(2 * `IO_POLL_DIV);
        check_value("pad_empty", 0, pad_empty);
        check_value("pad_rd_data", second, pad_rd_data);
        pop_button_event();
        check_value("pad_empty", 1, pad_empty);

        // Burst of four frames starts just after a tick so none leave mid burst
        sync_to_sample_tick();
        write_frames(4, 4);
        expect_frames();

        // Empty FIFO ticks count one underrun each
        base = audio_underruns;
        sync_to_sample_tick();
        check_value("audio_underruns", base + 8'd1, audio_underruns);
        wait_cycles(`IO_SAMPLE_DIV);
        check_value("audio_underruns", base + 8'd2, audio_underruns);

        // Six writes into a depth four FIFO, the last two are lost
        write_frames(6, `IO_FIFO_DEPTH);
        check_value("audio_full", 1, audio_full);
        expect_frames();
        check_value("audio_full", 0, audio_full);
        expect_no_frames(2 * `IO_SAMPLE_DIV);

        wait_cycles(4);
        $display("Checks done: %0d data errors, %0d assertion failures",
                 errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+design
design/pad_types_pkg.sv
design/audio_types_pkg.sv
design/io_control.sv
design/pad_poller.sv
design/event_fifo.sv
design/audio_output.sv
design/console_io_top.sv
tb/console_io_chk.sv
tb/console_io_tb.sv
